// ==== flist.f ====
+incdir+dv
src/htu_geom_pkg.sv
src/htu_proto_pkg.sv
src/htu_way_entry.sv
src/htu_set_entry.sv
src/htu_lookup.sv
src/bank_htu.sv
dv/tb_bank_htu.sv

// ==== Makefile ====
TOP = tb_bank_htu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; exit 1)
	cat sim.log
	! grep -q "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/tb_bank_htu_model.svh ====
// ----------------------------------------
// tag store model
// ----------------------------------------
logic             m_valid [SET_NUM][WAY_NUM];
logic [TAG_W-1:0] m_tag   [SET_NUM][WAY_NUM];
logic [1:0]       m_state [SET_NUM][WAY_NUM][2];
int               m_ptr   [SET_NUM];
int               err_cnt = 0;

typedef struct packed {
  logic                   hit;
  logic [WAY_W-1:0]       way;
  logic                   refill;
  logic                   evict;
  logic [1:0]             isu_op;
  logic [1:0]             half0;
  logic [1:0]             half1;
  logic [LINE_ADDR_W-1:0] awaddr;
} exp_t;

task automatic reset_model();
  for (int s = 0; s < SET_NUM; s++) begin
    m_ptr[s] = 0;
    for (int w = 0; w < WAY_NUM; w++) begin
      m_valid[s][w]    = 1'b0;
      m_tag[s][w]      = '0;
      m_state[s][w][0] = LINE_EMPTY;
      m_state[s][w][1] = LINE_EMPTY;
    end
  end
endtask

// expected lookup result for the request on the inputs
function automatic exp_t expect_out(logic valid, logic [1:0] op, htu_addr_u a);
  exp_t e;
  int   s;
  int   v;
  int   w;
  logic vic_dirty;
  e = '0;
  s = int'(a.tih.index);
  v = m_ptr[s];
  w = v;
  for (int i = 0; i < WAY_NUM; i++) begin
    if (m_valid[s][i] && (m_tag[s][i] == a.tih.tag)) begin
      e.hit = 1'b1;
      w     = i;
    end
  end
  // victim is the pointer way, hit or not
  vic_dirty = valid && m_valid[s][v] &&
              ((m_state[s][v][0] == LINE_DIRTY) || (m_state[s][v][1] == LINE_DIRTY));
  e.awaddr = {vic_dirty ? m_tag[s][v] : TAG_W'(0), a.tih.bank, a.tih.index};
  e.isu_op[ISU_OP_WRITE_BIT] = (op == OP_WRITE);
  if (valid) begin
    e.way    = WAY_W'(w);
    e.half0  = m_state[s][w][0];
    e.half1  = m_state[s][w][1];
    e.refill = (op == OP_READ) && (!e.hit || (m_state[s][w][a.tih.half] == LINE_EMPTY));
    e.evict  = !e.hit && vic_dirty;
  end
  e.isu_op[ISU_OP_EVICT_BIT] = e.evict;
  return e;
endfunction

task automatic apply_request(logic [1:0] op, htu_addr_u a);
  exp_t e;
  int   s;
  int   w;
  e = expect_out(1'b1, op, a);
  s = int'(a.tih.index);
  w = int'(e.way);
  if (!e.hit) begin
    m_valid[s][w]    = 1'b1;
    m_tag[s][w]      = a.tih.tag;
    m_state[s][w][0] = LINE_EMPTY;
    m_state[s][w][1] = LINE_EMPTY;
    m_ptr[s]         = (m_ptr[s] + 1) % WAY_NUM;
  end
  if (op == OP_WRITE) m_state[s][w][a.tih.half] = LINE_DIRTY;
endtask

// a finished fill turns empty halves clean
task automatic apply_done(logic [INDEX_W+WAY_W-1:0] sw);
  int s;
  int w;
  s = int'(sw[WAY_W +: INDEX_W]);
  w = int'(sw[WAY_W-1:0]);
  for (int h = 0; h < 2; h++) begin
    if (m_state[s][w][h] == LINE_EMPTY) m_state[s][w][h] = LINE_CLEAN;
  end
endtask

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic report(string name, logic [31:0] exp, logic [31:0] got);
  $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
  err_cnt++;
endtask
task automatic check_bit(string name, logic exp, logic got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_code(string name, logic [1:0] exp, logic [1:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_way(string name, logic [WAY_W-1:0] exp, logic [WAY_W-1:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_index(string name, logic [INDEX_W-1:0] exp, logic [INDEX_W-1:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_set_way(string name, logic [INDEX_W+WAY_W-1:0] exp,
                             logic [INDEX_W+WAY_W-1:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_swo(string name, logic [INDEX_W+WAY_W:0] exp, logic [INDEX_W+WAY_W:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_byte(string name, logic [7:0] exp, logic [7:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask
task automatic check_line(string name, logic [LINE_ADDR_W-1:0] exp, logic [LINE_ADDR_W-1:0] got);
  if (got !== exp) report(name, 32'(exp), 32'(got));
endtask

// ==== dv/tb_bank_htu.sv ====
`timescale 1ns/1ps

module tb_bank_htu import htu_geom_pkg::*, htu_proto_pkg::*; ();

  localparam int WAY_NUM = 4;
  localparam int N_DIR   = 7 + WAY_NUM;
  localparam int N_RAND  = 400;
  localparam int TIMEOUT = (N_DIR + N_RAND + 3) * 20 * 2;

  logic                       clk_i;
  logic                       rst_n_i;
  logic                       xbar_valid_i;
  logic                       xbar_allow_in_o;
  logic [1:0]                 xbar_ch_id_i;
  logic [1:0]                 xbar_opcode_i;
  htu_addr_u                  xbar_addr_i;
  logic [7:0]                 xbar_wbuffer_id_i;
  logic                       isu_allow_in_i;
  logic                       isu_valid_o;
  logic [1:0]                 isu_ch_id_o;
  logic [1:0]                 isu_opcode_o;
  logic [INDEX_W+WAY_W:0]     isu_set_way_offset_o;
  logic [7:0]                 isu_wbuffer_id_o;
  logic [1:0]                 isu_half0_state_o;
  logic [1:0]                 isu_half1_state_o;
  logic                       isu_linefill_valid_o;
  logic [INDEX_W-1:0]         isu_linefill_set_o;
  logic [WAY_W-1:0]           isu_linefill_way_o;
  logic                       isu_done_valid_i;
  logic [INDEX_W+WAY_W-1:0]   isu_done_set_way_i;
  logic [INDEX_W+WAY_W-1:0]   biu_set_way_o;
  logic                       biu_arvalid_o;
  logic [LINE_ADDR_W-1:0]     biu_araddr_o;
  logic                       biu_awvalid_o;
  logic [LINE_ADDR_W-1:0]     biu_awaddr_o;
  integer                     seed = 32'hf45a;

  `include "tb_bank_htu_model.svh"

  bank_htu #(.WAY_NUM(WAY_NUM)) i_bank_htu (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic htu_addr_u make_addr(logic [TAG_W-1:0] tag, logic [INDEX_W-1:0] idx,
                                          logic half);
    htu_addr_u a;
    a.tih.tag   = tag;
    a.tih.bank  = 2'b01;
    a.tih.index = idx;
    a.tih.half  = half;
    return a;
  endfunction

  // one request cycle driven on the falling edge
  task automatic drive_cycle(logic v, logic [1:0] op, htu_addr_u a, logic allow,
                             logic dv, logic [INDEX_W+WAY_W-1:0] dsw);
    logic [31:0] r;
    @(negedge clk_i);
    r                  = $random(seed);
    xbar_valid_i       = v;
    xbar_opcode_i      = op;
    xbar_addr_i        = a;
    xbar_ch_id_i       = r[1:0];
    xbar_wbuffer_id_i  = r[15:8];
    isu_allow_in_i     = allow;
    isu_done_valid_i   = dv;
    isu_done_set_way_i = dsw;
  endtask

  task automatic check_and_update();
    exp_t e;
    e = expect_out(xbar_valid_i, xbar_opcode_i, xbar_addr_i);
    check_bit("xbar_allow_in_o", isu_allow_in_i, xbar_allow_in_o);
    check_bit("isu_valid_o", xbar_valid_i, isu_valid_o);
    check_code("isu_ch_id_o", xbar_ch_id_i, isu_ch_id_o);
    check_code("isu_opcode_o", e.isu_op, isu_opcode_o);
    check_swo("isu_set_way_offset_o", {xbar_addr_i.tih.index, e.way, xbar_addr_i.tih.half},
              isu_set_way_offset_o);
    check_byte("isu_wbuffer_id_o", xbar_wbuffer_id_i, isu_wbuffer_id_o);
    check_code("isu_half0_state_o", e.half0, isu_half0_state_o);
    check_code("isu_half1_state_o", e.half1, isu_half1_state_o);
    check_bit("isu_linefill_valid_o", e.refill, isu_linefill_valid_o);
    check_index("isu_linefill_set_o", xbar_addr_i.tih.index, isu_linefill_set_o);
    check_way("isu_linefill_way_o", e.way, isu_linefill_way_o);
    check_set_way("biu_set_way_o", {xbar_addr_i.tih.index, e.way}, biu_set_way_o);
    check_bit("biu_arvalid_o", e.refill, biu_arvalid_o);
    check_line("biu_araddr_o",
               {xbar_addr_i.tih.tag, xbar_addr_i.tih.bank, xbar_addr_i.tih.index},
               biu_araddr_o);
    check_bit("biu_awvalid_o", e.evict, biu_awvalid_o);
    check_line("biu_awaddr_o", e.awaddr, biu_awaddr_o);
    if (xbar_valid_i && isu_allow_in_i) apply_request(xbar_opcode_i, xbar_addr_i);
    if (isu_done_valid_i) apply_done(isu_done_set_way_i);
  endtask

  // compare just before each rising edge
  initial begin
    forever begin
      @(negedge clk_i);
      #9;
      if (rst_n_i) check_and_update();
    end
  end

  initial begin
    htu_addr_u   a;
    logic [31:0] r;
    logic        v;
    logic        allow;
    int          dw;
    reset_model();
    rst_n_i            = 1'b0;
    xbar_valid_i       = 1'b0;
    xbar_ch_id_i       = '0;
    xbar_opcode_i      = OP_READ;
    xbar_addr_i        = '0;
    xbar_wbuffer_id_i  = '0;
    isu_allow_in_i     = 1'b1;
    isu_done_valid_i   = 1'b0;
    isu_done_set_way_i = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // miss after reset, fill, then read and write hits on set 2
    a = make_addr(TAG_W'(10), 3'd2, 1'b0);
    drive_cycle(1'b1, OP_READ, a, 1'b1, 1'b0, '0);
    drive_cycle(1'b0, OP_READ, a, 1'b1, 1'b1, {3'd2, 3'd0});
    drive_cycle(1'b1, OP_READ, a, 1'b1, 1'b0, '0);
    drive_cycle(1'b1, OP_WRITE, make_addr(TAG_W'(10), 3'd2, 1'b1), 1'b1, 1'b0, '0);
    // held request under back-pressure
    drive_cycle(1'b1, OP_READ, make_addr(TAG_W'(11), 3'd2, 1'b0), 1'b0, 1'b0, '0);
    drive_cycle(1'b1, OP_READ, make_addr(TAG_W'(11), 3'd2, 1'b0), 1'b0, 1'b0, '0);
    // round robin wraps back to the dirty way 0
    for (int i = 1; i <= WAY_NUM; i++) begin
      drive_cycle(1'b1, OP_READ, make_addr(TAG_W'(10 + i), 3'd2, 1'b0), 1'b1, 1'b0, '0);
    end
    drive_cycle(1'b0, OP_READ, a, 1'b1, 1'b0, '0);

    // random stream over four tags per set
    for (int n = 0; n < N_RAND; n++) begin
      r     = $random(seed);
      a     = make_addr(TAG_W'(32'h100 + r[1:0]), r[4:2], r[5]);
      v     = r[6] | r[7];
      allow = r[11:9] != 3'd0;
      dw    = int'(r[14:12]) % WAY_NUM;
      drive_cycle(v, {1'b0, r[8]}, a, allow,
                  r[18] && m_valid[int'(r[17:15])][dw] &&
                  !(v && allow && (r[17:15] == a.tih.index)),
                  {r[17:15], WAY_W'(dw)});
    end
    drive_cycle(1'b0, OP_READ, a, 1'b1, 1'b0, '0);
    repeat (2) @(negedge clk_i);

    $display("checks done, error count %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("timeout: stimulus did not complete within %0d ns", TIMEOUT);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== src/bank_htu.sv ====
`timescale 1ns/1ps

module bank_htu import htu_geom_pkg::*; #(
  parameter int WAY_NUM = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // crossbar request
  input  logic                         xbar_valid_i,
  output logic                         xbar_allow_in_o,
  input  logic [1:0]                   xbar_ch_id_i,
  input  logic [1:0]                   xbar_opcode_i,
  input  htu_addr_u                    xbar_addr_i,
  input  logic [7:0]                   xbar_wbuffer_id_i,
  // issue unit
  input  logic                         isu_allow_in_i,
  output logic                         isu_valid_o,
  output logic [1:0]                   isu_ch_id_o,
  output logic [1:0]                   isu_opcode_o,
  output logic [INDEX_W+WAY_W:0]       isu_set_way_offset_o,
  output logic [7:0]                   isu_wbuffer_id_o,
  output logic [1:0]                   isu_half0_state_o,
  output logic [1:0]                   isu_half1_state_o,
  output logic                         isu_linefill_valid_o,
  output logic [INDEX_W-1:0]           isu_linefill_set_o,
  output logic [WAY_W-1:0]             isu_linefill_way_o,
  input  logic                         isu_done_valid_i,
  input  logic [INDEX_W+WAY_W-1:0]     isu_done_set_way_i,
  // bus interface
  output logic [INDEX_W+WAY_W-1:0]     biu_set_way_o,
  output logic                         biu_arvalid_o,
  output logic [LINE_ADDR_W-1:0]       biu_araddr_o,
  output logic                         biu_awvalid_o,
  output logic [LINE_ADDR_W-1:0]       biu_awaddr_o
);

  logic [SET_NUM-1:0]            set_sel;
  logic [TAG_W-1:0]              acc_tag;
  logic                          acc_half;
  logic                          acc_write;
  logic                          accept;
  logic [SET_NUM-1:0]            set_hit;
  logic [SET_NUM-1:0][WAY_W-1:0] set_way;
  logic [SET_NUM-1:0]            set_victim_dirty;
  logic [SET_NUM-1:0][TAG_W-1:0] set_victim_tag;
  logic [SET_NUM-1:0][1:0]       set_half0_state;
  logic [SET_NUM-1:0][1:0]       set_half1_state;

  htu_lookup i_lookup (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .xbar_valid_i        (xbar_valid_i),
    .xbar_ch_id_i        (xbar_ch_id_i),
    .xbar_opcode_i       (xbar_opcode_i),
    .xbar_addr_i         (xbar_addr_i),
    .xbar_wbuffer_id_i   (xbar_wbuffer_id_i),
    .isu_allow_in_i      (isu_allow_in_i),
    .set_hit_i           (set_hit),
    .set_way_i           (set_way),
    .set_victim_dirty_i  (set_victim_dirty),
    .set_victim_tag_i    (set_victim_tag),
    .set_half0_state_i   (set_half0_state),
    .set_half1_state_i   (set_half1_state),
    .set_sel_o           (set_sel),
    .acc_tag_o           (acc_tag),
    .acc_half_o          (acc_half),
    .acc_write_o         (acc_write),
    .accept_o            (accept),
    .xbar_allow_in_o     (xbar_allow_in_o),
    .isu_valid_o         (isu_valid_o),
    .isu_ch_id_o         (isu_ch_id_o),
    .isu_opcode_o        (isu_opcode_o),
    .isu_set_way_offset_o(isu_set_way_offset_o),
    .isu_wbuffer_id_o    (isu_wbuffer_id_o),
    .isu_half0_state_o   (isu_half0_state_o),
    .isu_half1_state_o   (isu_half1_state_o),
    .isu_linefill_valid_o(isu_linefill_valid_o),
    .isu_linefill_set_o  (isu_linefill_set_o),
    .isu_linefill_way_o  (isu_linefill_way_o),
    .biu_set_way_o       (biu_set_way_o),
    .biu_arvalid_o       (biu_arvalid_o),
    .biu_araddr_o        (biu_araddr_o),
    .biu_awvalid_o       (biu_awvalid_o),
    .biu_awaddr_o        (biu_awaddr_o)
  );

  // ----------------------------------------
  // set array
  // ----------------------------------------
  for (genvar s = 0; s < SET_NUM; s++) begin : g_set
    htu_set_entry #(
      .WAY_NUM(WAY_NUM)
    ) i_set (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .set_sel_i     (set_sel[s]),
      .accept_i      (accept),
      .acc_tag_i     (acc_tag),
      .acc_half_i    (acc_half),
      .acc_write_i   (acc_write),
      // done report routed by its set field
      .done_valid_i  (isu_done_valid_i &&
                      (isu_done_set_way_i[WAY_W +: INDEX_W] == INDEX_W'(s))),
      .done_way_i    (isu_done_set_way_i[WAY_W-1:0]),
      .hit_o         (set_hit[s]),
      .way_o         (set_way[s]),
      .victim_dirty_o(set_victim_dirty[s]),
      .victim_tag_o  (set_victim_tag[s]),
      .half0_state_o (set_half0_state[s]),
      .half1_state_o (set_half1_state[s])
    );
  end

endmodule

// ==== src/htu_lookup.sv ====
`timescale 1ns/1ps

module htu_lookup import htu_geom_pkg::*, htu_proto_pkg::*; (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             xbar_valid_i,
  input  logic [1:0]                       xbar_ch_id_i,
  input  logic [1:0]                       xbar_opcode_i,
  input  htu_addr_u                        xbar_addr_i,
  input  logic [7:0]                       xbar_wbuffer_id_i,
  input  logic                             isu_allow_in_i,
  input  logic [SET_NUM-1:0]               set_hit_i,
  input  logic [SET_NUM-1:0][WAY_W-1:0]    set_way_i,
  input  logic [SET_NUM-1:0]               set_victim_dirty_i,
  input  logic [SET_NUM-1:0][TAG_W-1:0]    set_victim_tag_i,
  input  logic [SET_NUM-1:0][1:0]          set_half0_state_i,
  input  logic [SET_NUM-1:0][1:0]          set_half1_state_i,
  output logic [SET_NUM-1:0]               set_sel_o,
  output logic [TAG_W-1:0]                 acc_tag_o,
  output logic                             acc_half_o,
  output logic                             acc_write_o,
  output logic                             accept_o,
  output logic                             xbar_allow_in_o,
  output logic                             isu_valid_o,
  output logic [1:0]                       isu_ch_id_o,
  output logic [1:0]                       isu_opcode_o,
  output logic [INDEX_W+WAY_W:0]           isu_set_way_offset_o,
  output logic [7:0]                       isu_wbuffer_id_o,
  output logic [1:0]                       isu_half0_state_o,
  output logic [1:0]                       isu_half1_state_o,
  output logic                             isu_linefill_valid_o,
  output logic [INDEX_W-1:0]               isu_linefill_set_o,
  output logic [WAY_W-1:0]                 isu_linefill_way_o,
  output logic [INDEX_W+WAY_W-1:0]         biu_set_way_o,
  output logic                             biu_arvalid_o,
  output logic [LINE_ADDR_W-1:0]           biu_araddr_o,
  output logic                             biu_awvalid_o,
  output logic [LINE_ADDR_W-1:0]           biu_awaddr_o
);

  logic               op_read;
  logic               op_write;
  logic [INDEX_W-1:0] req_index;
  logic               hit;
  logic [WAY_W-1:0]   acc_way;
  logic               victim_dirty;
  logic [TAG_W-1:0]   victim_tag;
  logic [1:0]         half0_state;
  logic [1:0]         half1_state;
  logic [1:0]         acc_state;
  logic               need_refill;
  logic               need_evict;

  // ----------------------------------------
  // request decode
  // ----------------------------------------
  assign op_read   = xbar_opcode_i == OP_READ;
  assign op_write  = xbar_opcode_i == OP_WRITE;
  assign req_index = xbar_addr_i.tih.index;

  assign set_sel_o   = {{(SET_NUM-1){1'b0}}, xbar_valid_i} << req_index;
  assign acc_tag_o   = xbar_addr_i.tih.tag;
  assign acc_half_o  = xbar_addr_i.tih.half;
  assign acc_write_o = op_write;
  assign accept_o    = xbar_valid_i && isu_allow_in_i;

  // unselected sets return zero
  always_comb begin
    hit          = 1'b0;
    acc_way      = '0;
    victim_dirty = 1'b0;
    victim_tag   = '0;
    half0_state  = '0;
    half1_state  = '0;
    for (int s = 0; s < SET_NUM; s++) begin
      hit          = hit | set_hit_i[s];
      acc_way      = acc_way | set_way_i[s];
      victim_dirty = victim_dirty | set_victim_dirty_i[s];
      victim_tag   = victim_tag | set_victim_tag_i[s];
      half0_state  = half0_state | set_half0_state_i[s];
      half1_state  = half1_state | set_half1_state_i[s];
    end
  end

  assign acc_state = acc_half_o ? half1_state : half0_state;

  // read miss, or hit on a half that is still empty
  assign need_refill = xbar_valid_i && op_read && (!hit || (acc_state == LINE_EMPTY));
  assign need_evict  = xbar_valid_i && !hit && victim_dirty;

  // ----------------------------------------
  // towards ISU
  // ----------------------------------------
  assign xbar_allow_in_o      = isu_allow_in_i;
  assign isu_valid_o          = xbar_valid_i;
  assign isu_ch_id_o          = xbar_ch_id_i;
  assign isu_wbuffer_id_o     = xbar_wbuffer_id_i;
  assign isu_half0_state_o    = half0_state;
  assign isu_half1_state_o    = half1_state;
  assign isu_set_way_offset_o = {req_index, acc_way, acc_half_o};
  assign isu_linefill_valid_o = need_refill;
  assign isu_linefill_set_o   = req_index;
  assign isu_linefill_way_o   = acc_way;

  always_comb begin
    isu_opcode_o                   = '0;
    isu_opcode_o[ISU_OP_WRITE_BIT] = op_write;
    isu_opcode_o[ISU_OP_EVICT_BIT] = need_evict;
  end

  // ----------------------------------------
  // towards BIU
  // ----------------------------------------
  assign biu_set_way_o = {req_index, acc_way};
  assign biu_arvalid_o = need_refill;
  assign biu_araddr_o  = xbar_addr_i.lh.line_addr;
  assign biu_awvalid_o = need_evict;
  // bank bits are the same for every line held here
  assign biu_awaddr_o  = {victim_tag, xbar_addr_i.tih.bank, req_index};

  a_no_flush_inval: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    xbar_valid_i |-> ((xbar_opcode_i != OP_FLUSH) && (xbar_opcode_i != OP_INVAL))
  );

endmodule

// ==== src/htu_set_entry.sv ====
`timescale 1ns/1ps

module htu_set_entry import htu_geom_pkg::*, htu_proto_pkg::*; #(
  parameter int WAY_NUM = 8
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             set_sel_i,
  input  logic             accept_i,
  input  logic [TAG_W-1:0] acc_tag_i,
  input  logic             acc_half_i,
  input  logic             acc_write_i,
  input  logic             done_valid_i,
  input  logic [WAY_W-1:0] done_way_i,
  output logic             hit_o,
  output logic [WAY_W-1:0] way_o,
  output logic             victim_dirty_o,
  output logic [TAG_W-1:0] victim_tag_o,
  output logic [1:0]       half0_state_o,
  output logic [1:0]       half1_state_o
);

  logic [WAY_NUM-1:0] way_match;
  logic [WAY_NUM-1:0] way_valid;
  logic [WAY_NUM-1:0] way_alloc;
  logic [WAY_NUM-1:0] way_dirty;
  logic [WAY_NUM-1:0] way_fill;
  logic [TAG_W-1:0]   way_tag   [WAY_NUM];
  logic [1:0]         way_half0 [WAY_NUM];
  logic [1:0]         way_half1 [WAY_NUM];

  logic               hit;
  logic [WAY_W-1:0]   hit_way;
  logic [WAY_W-1:0]   acc_way;
  logic [WAY_W-1:0]   ptr_q;
  logic               set_acc;
  logic [1:0]         acc_half0;
  logic [1:0]         acc_half1;
  logic               vic_dirty;
  logic [TAG_W-1:0]   vic_tag;
  logic               done_way_valid;

  // ----------------------------------------
  // hit / victim select
  // ----------------------------------------
  assign hit     = |way_match;
  assign acc_way = hit ? hit_way : ptr_q;
  assign set_acc = set_sel_i && accept_i;

  always_comb begin
    hit_way        = '0;
    acc_half0      = '0;
    acc_half1      = '0;
    vic_dirty      = 1'b0;
    vic_tag        = '0;
    done_way_valid = 1'b0;
    for (int w = 0; w < WAY_NUM; w++) begin
      if (way_match[w]) hit_way = WAY_W'(w);
      if (acc_way == WAY_W'(w)) begin
        acc_half0 = way_half0[w];
        acc_half1 = way_half1[w];
      end
      if (ptr_q == WAY_W'(w)) begin
        vic_dirty = way_valid[w] &&
                    ((way_half0[w] == LINE_DIRTY) || (way_half1[w] == LINE_DIRTY));
        vic_tag   = way_tag[w];
      end
      if (done_way_i == WAY_W'(w)) done_way_valid = way_valid[w];
    end
  end

  // round-robin victim pointer moves on every allocation
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (set_acc && !hit) begin
      ptr_q <= (ptr_q == WAY_W'(WAY_NUM - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

  // ----------------------------------------
  // way array
  // ----------------------------------------
  for (genvar w = 0; w < WAY_NUM; w++) begin : g_way
    assign way_alloc[w] = set_acc && !hit && (ptr_q == WAY_W'(w));
    assign way_dirty[w] = set_acc && acc_write_i && (acc_way == WAY_W'(w));
    assign way_fill[w]  = done_valid_i && (done_way_i == WAY_W'(w));

    htu_way_entry i_way (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .acc_tag_i    (acc_tag_i),
      .acc_half_i   (acc_half_i),
      .alloc_i      (way_alloc[w]),
      .mark_dirty_i (way_dirty[w]),
      .fill_i       (way_fill[w]),
      .match_o      (way_match[w]),
      .valid_o      (way_valid[w]),
      .tag_o        (way_tag[w]),
      .half0_state_o(way_half0[w]),
      .half1_state_o(way_half1[w])
    );
  end

  // zero when not selected so the lookup can OR all sets
  assign hit_o          = set_sel_i && hit;
  assign way_o          = set_sel_i ? acc_way : '0;
  assign victim_dirty_o = set_sel_i && vic_dirty;
  assign victim_tag_o   = (set_sel_i && vic_dirty) ? vic_tag : '0;
  assign half0_state_o  = set_sel_i ? acc_half0 : LINE_EMPTY;
  assign half1_state_o  = set_sel_i ? acc_half1 : LINE_EMPTY;

  a_onehot_hit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(way_match)
  );

  // the ISU only fills a line it was told to refill
  a_done_valid_way: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    done_valid_i |-> done_way_valid
  );

endmodule

// ==== src/htu_way_entry.sv ====
`timescale 1ns/1ps

module htu_way_entry import htu_geom_pkg::*, htu_proto_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic [TAG_W-1:0] acc_tag_i,
  input  logic             acc_half_i,
  input  logic             alloc_i,
  input  logic             mark_dirty_i,
  input  logic             fill_i,
  output logic             match_o,
  output logic             valid_o,
  output logic [TAG_W-1:0] tag_o,
  output logic [1:0]       half0_state_o,
  output logic [1:0]       half1_state_o
);

  logic             valid_q;
  logic [TAG_W-1:0] tag_q;
  logic [1:0]       half0_q;
  logic [1:0]       half1_q;

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      tag_q <= acc_tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      half0_q <= LINE_EMPTY;
      half1_q <= LINE_EMPTY;
    end else begin
      // a new line starts empty, a fill only touches empty halves
      if (alloc_i) begin
        valid_q <= 1'b1;
        half0_q <= LINE_EMPTY;
        half1_q <= LINE_EMPTY;
      end else if (fill_i) begin
        if (half0_q == LINE_EMPTY) half0_q <= LINE_CLEAN;
        if (half1_q == LINE_EMPTY) half1_q <= LINE_CLEAN;
      end
      // write data lands in the accessed half
      if (mark_dirty_i) begin
        if (acc_half_i) half1_q <= LINE_DIRTY;
        else            half0_q <= LINE_DIRTY;
      end
    end
  end

  assign match_o       = valid_q && (tag_q == acc_tag_i);
  assign valid_o       = valid_q;
  assign tag_o         = tag_q;
  assign half0_state_o = half0_q;
  assign half1_state_o = half1_q;

  a_no_reserved_state: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (half0_q != 2'b10) && (half1_q != 2'b10)
  );

endmodule

// ==== src/htu_proto_pkg.sv ====
package htu_proto_pkg;

  // ----------------------------------------
  // crossbar opcodes
  // ----------------------------------------
  localparam logic [1:0] OP_READ  = 2'b00;
  localparam logic [1:0] OP_WRITE = 2'b01;

  // not served by this bank, only checked against
  localparam logic [1:0] OP_FLUSH = 2'b10;
  localparam logic [1:0] OP_INVAL = 2'b11;

  // ----------------------------------------
  // state of one 16-byte half
  // ----------------------------------------
  localparam logic [1:0] LINE_EMPTY = 2'b00;
  localparam logic [1:0] LINE_CLEAN = 2'b01;
  localparam logic [1:0] LINE_DIRTY = 2'b11;

  // ----------------------------------------
  // ISU opcode bits
  // ----------------------------------------
  // bit 0 high for a write, bit 1 high when a dirty victim goes out
  localparam int ISU_OP_WRITE_BIT = 0;
  localparam int ISU_OP_EVICT_BIT = 1;

endpackage

// ==== src/htu_geom_pkg.sv ====
package htu_geom_pkg;

  // ----------------------------------------
  // bank geometry
  // ----------------------------------------
  // fixed by the address layout below
  localparam int SET_NUM     = 8;
  localparam int INDEX_W     = 3;
  localparam int TAG_W       = 22;

  // way number on the ports fits up to 8 ways
  localparam int WAY_W       = 3;

  // 32-byte line address, bits 31:5
  localparam int LINE_ADDR_W = 27;

  // bank select bits 9:8 are resolved by the crossbar
  localparam int BANK_W      = 2;

  // ----------------------------------------
  // request address, bits 31:4
  // ----------------------------------------
  // lookup view for tag compare and set select,
  // line view for the refill address
  typedef union packed {
    struct packed {
      logic [TAG_W-1:0]   tag;
      logic [BANK_W-1:0]  bank;
      logic [INDEX_W-1:0] index;
      logic               half;
    } tih;
    struct packed {
      logic [LINE_ADDR_W-1:0] line_addr;
      logic                   half;
    } lh;
  } htu_addr_u;

endpackage
